// File: verilog.f
+incdir+.
cnn_pkg.sv
weight_bank.sv
weight_store.sv
layer_sequencer.sv
channel_mac.sv
cnn_weight_engine.sv
cnn_weight_engine_asserts.sv
tb_cnn_weight_engine.sv

// File: Bender.yml
package:
  name: cnn_weight_engine

sources:
  - include_dirs:
      - .
    files:
      - cnn_pkg.sv
      - weight_bank.sv
      - weight_store.sv
      - layer_sequencer.sv
      - channel_mac.sv
      - cnn_weight_engine.sv
  - target: test
    include_dirs:
      - .
    files:
      - cnn_weight_engine_asserts.sv
      - tb_cnn_weight_engine.sv

// File: tb_cnn_weight_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defs.svh"

module tb_cnn_weight_engine;

  localparam int LAYER_WORDS = `NUM_PHASE * `WORDS_PER_VEC;
  localparam int VEC_VALS = `WORDS_PER_VEC * 9;
  localparam int RUN_CYCLES = 66;
  // Bank fill is about 1300 cycles, the runs well under 1000.
  localparam int MAX_CYCLES = 20000;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 start;
  cnn_pkg::layer_e      layer;
  cnn_pkg::weight_vec_t act_vec;
  logic                 wr_en;
  logic [1:0]           wr_ch;
  cnn_pkg::bank_addr_t  wr_addr;
  cnn_pkg::bank_word_t  wr_data;
  wire                  busy;
  wire                  done;
  wire cnn_pkg::acc_t   result [`NUM_CH];

  integer              seed = 32'heef0;
  int                  cycle_count = 0;
  cnn_pkg::bank_word_t model [`NUM_CH][`BANK_DEPTH];
  int                  saved [`NUM_CH];

  cnn_weight_engine DUT (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .layer   (layer),
    .act_vec (act_vec),
    .wr_en   (wr_en),
    .wr_ch   (wr_ch),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .busy    (busy),
    .done    (done),
    .result  (result)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $fatal(1, "Watchdog expired");
    end
  end

  ////////////////////////////////////////
  // Helpers.
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  // Word in slot s meets activations 9*s to 9*s+8.
  function automatic int word_dot(input cnn_pkg::bank_word_t word,
                                  input cnn_pkg::weight_vec_t act, input int slot);
    logic signed [`DATA_LEN-1:0] w;
    logic signed [`DATA_LEN-1:0] a;
    int sum;
    sum = 0;
    for (int i = 0; i < 9; i++) begin
      w = word[i*`DATA_LEN +: `DATA_LEN];
      a = act[(slot*9+i)*`DATA_LEN +: `DATA_LEN];
      sum += int'(w) * int'(a);
    end
    return sum;
  endfunction

  function automatic int expected_result(input int ch, input int lyr,
                                         input cnn_pkg::weight_vec_t act);
    int sum;
    sum = 0;
    for (int p = 0; p < `NUM_PHASE; p++) begin
      for (int w = 0; w < `WORDS_PER_VEC; w++) begin
        sum += word_dot(model[ch][lyr*LAYER_WORDS + p*`WORDS_PER_VEC + w], act, w);
      end
    end
    return sum;
  endfunction

  task automatic random_word(output cnn_pkg::bank_word_t word);
    word = cnn_pkg::bank_word_t'({$random(seed), $random(seed), $random(seed)});
  endtask

  task automatic random_vec(output cnn_pkg::weight_vec_t vec);
    for (int j = 0; j < 9; j++) begin
      vec[j*32 +: 32] = $random(seed);
    end
  endtask

  task automatic write_word(input int ch, input int addr, input cnn_pkg::bank_word_t data);
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_ch   <= 2'(ch);
    wr_addr <= cnn_pkg::bank_addr_t'(addr);
    wr_data <= data;
    model[ch][addr] = data;
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  // Latency counts the start cycle, so done lands on count 66.
  task automatic run_layer(input cnn_pkg::layer_e l, input int restart_at,
                           output int latency, output int busy_cycles);
    @(posedge clk);
    start <= 1'b1;
    layer <= l;
    latency = 0;
    busy_cycles = 0;
    do begin
      @(negedge clk);
      latency++;
      if (busy) busy_cycles++;
      if (!done) begin
        @(posedge clk);
        start <= (latency == restart_at);
        layer <= (latency == restart_at) ? cnn_pkg::AFFINE : l;
      end
    end while (!done);
  endtask

  task automatic check_results(input string name, input cnn_pkg::layer_e l);
    for (int ch = 0; ch < `NUM_CH; ch++) begin
      check_value(name, expected_result(ch, int'(l), act_vec), result[ch]);
    end
  endtask

  ////////////////////////////////////////
  // Tests.
  ////////////////////////////////////////

  task automatic test_reset_fill();
    cnn_pkg::bank_word_t word;
    logic signed [`DATA_LEN-1:0] w;
    int latency, busy_cycles, sum;
    check_value("reset busy", 0, busy);
    check_value("reset done", 0, done);
    for (int ch = 0; ch < `NUM_CH; ch++) begin
      for (int addr = 0; addr < `BANK_DEPTH; addr++) begin
        random_word(word);
        write_word(ch, addr, word);
      end
    end
    act_vec <= {VEC_VALS{8'h01}};
    run_layer(cnn_pkg::LAYER0, 0, latency, busy_cycles);
    for (int ch = 0; ch < `NUM_CH; ch++) begin
      sum = 0;
      for (int addr = 0; addr < LAYER_WORDS; addr++) begin
        for (int i = 0; i < 9; i++) begin
          w = model[ch][addr][i*`DATA_LEN +: `DATA_LEN];
          sum += int'(w);
        end
      end
      check_value("layer0 weight sum", sum, result[ch]);
    end
  endtask

  task automatic test_all_layers();
    cnn_pkg::weight_vec_t vec;
    int latency, busy_cycles;
    for (int l = 1; l < 5; l++) begin
      random_vec(vec);
      @(posedge clk);
      act_vec <= vec;
      run_layer(cnn_pkg::layer_e'(l), 0, latency, busy_cycles);
      check_results("layer base", cnn_pkg::layer_e'(l));
    end
  endtask

  task automatic test_timing();
    int latency, busy_cycles;
    run_layer(cnn_pkg::LAYER3, 0, latency, busy_cycles);
    check_value("done latency", RUN_CYCLES, latency);
    // Busy rises in the cycle after start.
    check_value("busy cycles", RUN_CYCLES - 1, busy_cycles);
    @(negedge clk);
    check_value("busy after done", 0, busy);
  endtask

  task automatic test_isolation();
    cnn_pkg::weight_vec_t vec;
    cnn_pkg::bank_word_t word;
    int latency, busy_cycles, addr, delta;
    random_vec(vec);
    @(posedge clk);
    act_vec <= vec;
    run_layer(cnn_pkg::LAYER2, 0, latency, busy_cycles);
    check_results("isolation before", cnn_pkg::LAYER2);
    for (int ch = 0; ch < `NUM_CH; ch++) saved[ch] = result[ch];
    // Word 13 is slot 1 of phase 3.
    addr = 2 * LAYER_WORDS + 13;
    random_word(word);
    delta = word_dot(word, vec, 1) - word_dot(model[2][addr], vec, 1);
    write_word(2, addr, word);
    run_layer(cnn_pkg::LAYER2, 0, latency, busy_cycles);
    for (int ch = 0; ch < `NUM_CH; ch++) begin
      check_value("isolation after", (ch == 2) ? saved[ch] + delta : saved[ch], result[ch]);
    end
  endtask

  task automatic test_busy_start();
    cnn_pkg::weight_vec_t vec;
    int latency, busy_cycles;
    random_vec(vec);
    @(posedge clk);
    act_vec <= vec;
    run_layer(cnn_pkg::LAYER1, 20, latency, busy_cycles);
    check_value("restart latency", RUN_CYCLES, latency);
    check_results("start while busy", cnn_pkg::LAYER1);
    @(negedge clk);
    check_value("no second run", 0, busy);
    run_layer(cnn_pkg::LAYER0, 0, latency, busy_cycles);
    check_results("back to back first", cnn_pkg::LAYER0);
    run_layer(cnn_pkg::LAYER0, 0, latency, busy_cycles);
    check_results("back to back second", cnn_pkg::LAYER0);
  endtask

  task automatic test_signed_extremes();
    int latency, busy_cycles, base;
    base = 3 * LAYER_WORDS;
    for (int ch = 0; ch < `NUM_CH; ch++) begin
      for (int w = 0; w < LAYER_WORDS; w++) begin
        write_word(ch, base + w, (w / `WORDS_PER_VEC == 5) ? {9{8'h80}} : '0);
      end
    end
    act_vec <= {VEC_VALS{8'h80}};
    run_layer(cnn_pkg::LAYER3, 0, latency, busy_cycles);
    check_results("signed extremes model", cnn_pkg::LAYER3);
    for (int ch = 0; ch < `NUM_CH; ch++) begin
      check_value("signed extremes", VEC_VALS * 128 * 128, result[ch]);
    end
  endtask

  initial begin
    reset   <= 1'b1;
    start   <= 1'b0;
    layer   <= cnn_pkg::LAYER0;
    act_vec <= '0;
    wr_en   <= 1'b0;
    wr_ch   <= '0;
    wr_addr <= '0;
    wr_data <= '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    test_reset_fill();
    test_all_layers();
    test_timing();
    test_isolation();
    test_busy_start();
    test_signed_extremes();
    if (DUT.u_seq.u_asserts.error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("Bound assertions failed %0d times", DUT.u_seq.u_asserts.error_count);
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cnn_weight_engine_asserts.sv
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defs.svh"

module cnn_weight_engine_asserts (
  input wire               clk,
  input wire               reset,
  input wire               load,
  input wire [`NUM_CH-1:0] valid_all,
  input wire               acc_en,
  input wire               done
);

  int error_count = 0;

  ////////////////////////////////////////
  // Sequencer strobes.
  ////////////////////////////////////////

  done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
      error_count++;
      $error("done stayed high for more than one cycle");
    end

  acc_en_pulse: assert property (@(posedge clk) disable iff (reset) acc_en |=> !acc_en)
    else begin
      error_count++;
      $error("acc_en stayed high for more than one cycle");
    end

  // MAC is the last load cycle of a phase.
  load_gap: assert property (@(posedge clk) disable iff (reset) acc_en |=> !load)
    else begin
      error_count++;
      $error("load did not drop after the MAC cycle");
    end

  ////////////////////////////////////////
  // Store timing.
  ////////////////////////////////////////

  valid_rise: assert property (@(posedge clk) disable iff (reset)
      $rose(load) |-> (valid_all == '0) [*5] ##1 (&valid_all))
    else begin
      error_count++;
      $error("store valids did not rise six cycles after load");
    end

  valid_clear: assert property (@(posedge clk) disable iff (reset)
      !load |=> (valid_all == '0))
    else begin
      error_count++;
      $error("store valids not cleared after load dropped");
    end

endmodule

// Assertions ride on the sequencer instance.
bind layer_sequencer cnn_weight_engine_asserts u_asserts (
  .clk       (clk),
  .reset     (reset),
  .load      (ctl.load),
  .valid_all (valid_all),
  .acc_en    (acc_en),
  .done      (done)
);

`default_nettype wire

// File: cnn_weight_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defs.svh"

module cnn_weight_engine (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        start,
  input  wire cnn_pkg::layer_e       layer,
  input  wire cnn_pkg::weight_vec_t  act_vec,
  input  wire                        wr_en,
  input  wire [1:0]                  wr_ch,
  input  wire cnn_pkg::bank_addr_t   wr_addr,
  input  wire cnn_pkg::bank_word_t   wr_data,
  output wire                        busy,
  output wire                        done,
  output wire cnn_pkg::acc_t         result [`NUM_CH]
);

  wire cnn_pkg::fetch_ctl_t   ctl;
  wire cnn_pkg::bank_wr_t     bank_wr [`NUM_CH];
  wire [`NUM_CH-1:0]          valid_all;
  wire cnn_pkg::weight_vec_t  w_vec [`NUM_CH];
  wire                        clear_acc;
  wire                        acc_en;

  layer_sequencer u_seq (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .layer     (layer),
    .wr_en     (wr_en),
    .wr_ch     (wr_ch),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .valid_all (valid_all),
    .ctl       (ctl),
    .bank_wr   (bank_wr),
    .clear_acc (clear_acc),
    .acc_en    (acc_en),
    .busy      (busy),
    .done      (done)
  );

  ////////////////////////////////////////
  // Per-channel bank and fetcher.
  ////////////////////////////////////////

  for (genvar ch = 0; ch < `NUM_CH; ch++) begin : g_ch
    wire cnn_pkg::bank_addr_t rd_addr;
    wire cnn_pkg::bank_word_t rd_data;

    weight_bank u_bank (
      .clk     (clk),
      .wr      (bank_wr[ch]),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
    );

    weight_store u_store (
      .clk     (clk),
      .reset   (reset),
      .ctl     (ctl),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .valid   (valid_all[ch]),
      .q       (w_vec[ch])
    );
  end

  channel_mac u_mac (
    .clk       (clk),
    .reset     (reset),
    .clear_acc (clear_acc),
    .acc_en    (acc_en),
    .act_vec   (act_vec),
    .w_vec     (w_vec),
    .result    (result)
  );

endmodule

`default_nettype wire

// File: channel_mac.sv
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defs.svh"

module channel_mac (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        clear_acc,
  input  wire                        acc_en,
  input  wire cnn_pkg::weight_vec_t  act_vec,
  input  wire cnn_pkg::weight_vec_t  w_vec [`NUM_CH],
  output cnn_pkg::acc_t              result [`NUM_CH]
);

  localparam int NUM_TERMS = $bits(cnn_pkg::weight_vec_t) / `DATA_LEN;

  // Signed dot product of two 36-value vectors.
  function automatic cnn_pkg::acc_t dot(input cnn_pkg::weight_vec_t w,
                                        input cnn_pkg::weight_vec_t a);
    cnn_pkg::acc_t               sum;
    cnn_pkg::data_t              w_i;
    cnn_pkg::data_t              a_i;
    logic signed [2*`DATA_LEN-1:0] prod;
    sum = '0;
    for (int i = 0; i < NUM_TERMS; i++) begin
      w_i  = w[i*`DATA_LEN +: `DATA_LEN];
      a_i  = a[i*`DATA_LEN +: `DATA_LEN];
      prod = $signed(w_i) * $signed(a_i);
      sum  = sum + prod;
    end
    return sum;
  endfunction

  for (genvar ch = 0; ch < `NUM_CH; ch++) begin : g_ch
    cnn_pkg::acc_t dot_sum;

    assign dot_sum = dot(w_vec[ch], act_vec);

    // Clear at layer start, one add per phase.
    always_ff @(posedge clk) begin
      if (reset || clear_acc) begin
        result[ch] <= '0;
      end else if (acc_en) begin
        result[ch] <= result[ch] + dot_sum;
      end
    end
  end

endmodule

`default_nettype wire

// File: layer_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defs.svh"

module layer_sequencer (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      start,
  input  wire cnn_pkg::layer_e     layer,
  input  wire                      wr_en,
  input  wire [1:0]                wr_ch,
  input  wire cnn_pkg::bank_addr_t wr_addr,
  input  wire cnn_pkg::bank_word_t wr_data,
  input  wire [`NUM_CH-1:0]        valid_all,
  output cnn_pkg::fetch_ctl_t      ctl,
  output cnn_pkg::bank_wr_t        bank_wr [`NUM_CH],
  output logic                     clear_acc,
  output logic                     acc_en,
  output logic                     busy,
  output logic                     done
);

  cnn_pkg::seq_state_e state;
  cnn_pkg::seq_state_e state_next;
  cnn_pkg::layer_e     layer_q;
  cnn_pkg::phase_t     phase;
  logic                launch;
  logic                last_phase;

  assign launch     = (state == cnn_pkg::IDLE) && start;
  assign last_phase = (phase == cnn_pkg::phase_t'(`NUM_PHASE - 1));

  ////////////////////////////////////////
  // Phase FSM.
  ////////////////////////////////////////

  // Eight cycles per phase: six of FETCH, then MAC, then GAP.
  always_comb begin
    state_next = state;
    case (state)
      cnn_pkg::IDLE:  if (start) state_next = cnn_pkg::FETCH;
      cnn_pkg::FETCH: if (&valid_all) state_next = cnn_pkg::MAC;
      cnn_pkg::MAC:   state_next = cnn_pkg::GAP;
      cnn_pkg::GAP:   state_next = last_phase ? cnn_pkg::DONE : cnn_pkg::FETCH;
      cnn_pkg::DONE:  state_next = cnn_pkg::IDLE;
      default:        state_next = cnn_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= cnn_pkg::IDLE;
      layer_q   <= cnn_pkg::LAYER0;
      phase     <= '0;
      clear_acc <= 1'b0;
    end else begin
      state     <= state_next;
      clear_acc <= launch;
      if (launch) begin
        layer_q <= layer;
        phase   <= '0;
      end else if (state == cnn_pkg::GAP) begin
        phase <= phase + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Outputs.
  ////////////////////////////////////////

  always_comb begin
    busy   = (state != cnn_pkg::IDLE);
    done   = (state == cnn_pkg::DONE);
    acc_en = (state == cnn_pkg::MAC);

    // Load falls in GAP so every store restarts its read burst.
    ctl.load  = (state == cnn_pkg::FETCH) || (state == cnn_pkg::MAC);
    ctl.layer = layer_q;
    ctl.phase = phase;

    // Host writes reach one bank, and only while idle.
    for (int ch = 0; ch < `NUM_CH; ch++) begin
      bank_wr[ch].en   = wr_en && !busy && (wr_ch == 2'(ch));
      bank_wr[ch].addr = wr_addr;
      bank_wr[ch].data = wr_data;
    end
  end

endmodule

`default_nettype wire

// File: weight_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defs.svh"

module weight_store (
  input  wire                       clk,
  input  wire                       reset,
  input  wire cnn_pkg::fetch_ctl_t  ctl,
  output cnn_pkg::bank_addr_t       rd_addr,
  input  wire cnn_pkg::bank_word_t  rd_data,
  output logic                      valid,
  output cnn_pkg::weight_vec_t      q
);

  localparam int WORD_W = $bits(cnn_pkg::bank_word_t);
  localparam int LAYER_WORDS = `NUM_PHASE * `WORDS_PER_VEC;
  localparam logic [2:0] LAST_CNT = 3'(`WORDS_PER_VEC);

  cnn_pkg::bank_addr_t layer_base;
  cnn_pkg::bank_addr_t vec_base;
  logic [2:0]          word_cnt;
  logic                rd_pend;
  logic [1:0]          slice;

  ////////////////////////////////////////
  // Address generation.
  ////////////////////////////////////////

  // Layer picks a 32-word region.
  assign layer_base = cnn_pkg::bank_addr_t'(LAYER_WORDS * ctl.layer);

  // Each phase owns four consecutive words.
  assign vec_base = layer_base + cnn_pkg::bank_addr_t'(`WORDS_PER_VEC * ctl.phase);

  assign rd_addr = vec_base + cnn_pkg::bank_addr_t'(word_cnt[1:0]);

  // The word on rd_data was requested one count earlier.
  assign slice = word_cnt[1:0] - 2'd1;

  ////////////////////////////////////////
  // Read sequencing.
  ////////////////////////////////////////

  // Word 0 is requested in the first load cycle, the init cycle.
  // Words land on the next four edges and valid rises with the
  // last one, so it is high from the sixth load cycle on.
  always_ff @(posedge clk) begin
    if (reset || !ctl.load) begin
      word_cnt <= '0;
      rd_pend  <= 1'b0;
      valid    <= 1'b0;
    end else begin
      rd_pend <= (word_cnt != LAST_CNT);
      if (word_cnt != LAST_CNT) begin
        word_cnt <= word_cnt + 3'd1;
      end
      if (rd_pend && word_cnt == LAST_CNT) begin
        valid <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Vector assembly.
  ////////////////////////////////////////

  // Word n fills slice n, lowest bits first.
  always_ff @(posedge clk) begin
    if (rd_pend) begin
      q[slice*WORD_W +: WORD_W] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: weight_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defs.svh"

module weight_bank (
  input  wire                      clk,
  input  wire cnn_pkg::bank_wr_t   wr,
  input  wire cnn_pkg::bank_addr_t rd_addr,
  output cnn_pkg::bank_word_t      rd_data
);

  cnn_pkg::bank_word_t mem [`BANK_DEPTH];

  ////////////////////////////////////////
  // Host write port.
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  ////////////////////////////////////////
  // Fetch read port.
  ////////////////////////////////////////

  // One cycle of read latency.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: cnn_pkg.sv
`default_nettype none

`include "cnn_defs.svh"

package cnn_pkg;

  typedef logic [`DATA_LEN-1:0] data_t;

  // Nine values per bank word.
  typedef logic [9*`DATA_LEN-1:0] bank_word_t;
  typedef logic [`WORDS_PER_VEC*9*`DATA_LEN-1:0] weight_vec_t;

  typedef logic [`BANK_AW-1:0] bank_addr_t;
  typedef logic [$clog2(`NUM_PHASE)-1:0] phase_t;
  typedef logic signed [`ACC_LEN-1:0] acc_t;

  // Order sets the bank base address, position times 32.
  typedef enum logic [2:0] {LAYER0, LAYER1, LAYER2, LAYER3, AFFINE} layer_e;

  typedef enum logic [2:0] {IDLE, FETCH, MAC, GAP, DONE} seq_state_e;

  typedef struct packed {
    logic       en;
    bank_addr_t addr;
    bank_word_t data;
  } bank_wr_t;

  typedef struct packed {
    logic   load;
    layer_e layer;
    phase_t phase;
  } fetch_ctl_t;

endpackage

`default_nettype wire

// File: cnn_defs.svh
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

// Signed weight and activation width.
`define DATA_LEN 8

// Number of weight store channels.
`define NUM_CH 4

// Bank words, five layers of 32 words each.
`define BANK_DEPTH 160
`define BANK_AW 8

// Bank words that make up one weight vector.
`define WORDS_PER_VEC 4

// Phases in one layer pass.
`define NUM_PHASE 8

// Running sum width per channel.
`define ACC_LEN 24

`endif
